/* verilog/link_pkg.sv */
// link layer types: lane byte, select code, select code values, ordered-set kinds
`default_nettype none

package link_pkg;

	//////////////////////////////
	// lane and select widths
	//////////////////////////////

	localparam int BYTE_BITS  = 8;
	localparam int BYTE_CNT_W = $clog2(BYTE_BITS); // bit position within a byte

	typedef logic [BYTE_BITS-1:0] lane_byte_t; // one byte on one lane
	typedef logic [3:0]           d_sel_t;     // code from the training FSM

	//////////////////////////////
	// select codes
	//////////////////////////////

	localparam d_sel_t SEL_SLOS1     = 4'h0;
	localparam d_sel_t SEL_SLOS2     = 4'h1;
	localparam d_sel_t SEL_GEN3_TS1  = 4'h2;
	localparam d_sel_t SEL_GEN3_TS2  = 4'h3;
	// 4'h4 would be gen4 ts1, not supported here so it idles
	localparam d_sel_t SEL_GEN4_TS2  = 4'h5;
	localparam d_sel_t SEL_GEN4_TS3  = 4'h6;
	localparam d_sel_t SEL_GEN4_TS4  = 4'h7;
	localparam d_sel_t SEL_TRANSPORT = 4'h8;
	localparam d_sel_t SEL_IDLE      = 4'hF; // any unlisted code behaves like this

	//////////////////////////////
	// ordered-set kinds
	//////////////////////////////

	// what the bit source walks once a set has been started
	typedef enum logic [2:0] {
		OS_SLOS1,
		OS_SLOS2,
		OS_GEN3_TS1,
		OS_GEN3_TS2,
		OS_GEN4_TS2,
		OS_GEN4_TS3,
		OS_GEN4_TS4
	} os_kind_t;

endpackage

`default_nettype wire

/* verilog/ordered_set_pkg.sv */
// ordered-set content: bit index, prbs and ts4 types, set lengths, seed, fixed patterns
`default_nettype none

package ordered_set_pkg;

	typedef logic [11:0] bit_count_t; // position inside a set, up to 2047
	typedef logic [10:0] prbs_t;      // prbs11 shift state
	typedef logic [3:0]  ts4_index_t; // running field of the gen4 ts4 header

	//////////////////////////////
	// set lengths in bits
	//////////////////////////////

	localparam bit_count_t LEN_SLOS = 12'd2048; // 256 whole bytes
	localparam bit_count_t LEN_GEN3 = 12'd64;
	localparam bit_count_t LEN_GEN4 = 12'd32;

	//////////////////////////////
	// prbs11 and ts4 counter
	//////////////////////////////

	localparam prbs_t PRBS_SEED = 11'd1;

	localparam ts4_index_t TS4_FIRST = 4'd1;
	localparam ts4_index_t TS4_LAST  = 4'd15; // wraps back to TS4_FIRST

	//////////////////////////////
	// gen3 training sets
	//////////////////////////////

	// lane 1 differs from lane 0 only in the lane number byte
	localparam logic [63:0] GEN3_TS1_LANE0 = 64'h01000000040098F2;
	localparam logic [63:0] GEN3_TS1_LANE1 = 64'h01010000040098F2;
	localparam logic [63:0] GEN3_TS2_LANE0 = 64'h01000000040064F2; // symbol 6 is 64 not 98
	localparam logic [63:0] GEN3_TS2_LANE1 = 64'h01010000040064F2;

	//////////////////////////////
	// gen4 headers
	//////////////////////////////

	localparam logic [31:0] GEN4_TS2_HEAD = 32'h7E04B0F0;
	localparam logic [31:0] GEN4_TS3_HEAD = 32'h7E0690F0;

	// bits 15..4 take {0, n, 15-n}, so n=1 gives 7E0F01E0
	localparam logic [31:0] GEN4_TS4_BASE = 32'h7E0F0000;

endpackage

`default_nettype wire

/* verilog/os_decode.sv */
// select decode: code sampling, set kind mapping, start strobe, transport path, abort level
`timescale 1ns/1ps
`default_nettype none

module os_decode
	import link_pkg::*;
(
	input  logic       fsm_clk,
	input  logic       rst,
	input  d_sel_t     d_sel,
	input  lane_byte_t transport_layer_data_in,
	input  logic       set_done,
	output logic       os_start,
	output os_kind_t   os_kind,
	output logic       transport_en,
	output lane_byte_t transport_byte,
	output logic       abort
);

	d_sel_t     sel_q;      // sampled code
	d_sel_t     sel_prev_q; // code one cycle earlier, for change detect
	lane_byte_t data_q;     // transport byte sampled alongside sel_q
	os_kind_t   kind_c;
	logic       is_os_c;

	//////////////////////////////
	// code to kind
	//////////////////////////////

	always_comb begin
		kind_c  = OS_SLOS1;
		is_os_c = 1'b1;
		case (sel_q)
			SEL_SLOS1:    kind_c = OS_SLOS1;
			SEL_SLOS2:    kind_c = OS_SLOS2;
			SEL_GEN3_TS1: kind_c = OS_GEN3_TS1;
			SEL_GEN3_TS2: kind_c = OS_GEN3_TS2;
			SEL_GEN4_TS2: kind_c = OS_GEN4_TS2;
			SEL_GEN4_TS3: kind_c = OS_GEN4_TS3;
			SEL_GEN4_TS4: kind_c = OS_GEN4_TS4;
			default:      is_os_c = 1'b0; // transport and idle codes
		endcase
	end

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			sel_q        <= SEL_IDLE;
			sel_prev_q   <= SEL_IDLE;
			os_start     <= 1'b0;
			os_kind      <= OS_SLOS1;
			transport_en <= 1'b0;
			abort        <= 1'b1; // lanes held at zero until a set code shows up
		end else begin
			sel_q      <= d_sel;
			sel_prev_q <= sel_q;
			// new set code, or same code held after the previous set went out
			os_start     <= is_os_c && ((sel_q != sel_prev_q) || set_done);
			os_kind      <= kind_c;
			transport_en <= (sel_q == SEL_TRANSPORT);
			abort        <= !is_os_c;
		end
	end

	// transport byte follows the same two stages as the code
	always_ff @(posedge fsm_clk) begin
		data_q         <= transport_layer_data_in;
		transport_byte <= data_q;
	end

endmodule

`default_nettype wire

/* verilog/os_bit_source.sv */
// bit source: prbs11 generator, fixed pattern walker, ts4 header counter, one bit per cycle
`timescale 1ns/1ps
`default_nettype none

module os_bit_source
	import link_pkg::*;
	import ordered_set_pkg::*;
(
	input  logic     fsm_clk,
	input  logic     rst,
	input  logic     os_start,
	input  os_kind_t os_kind,
	input  logic     abort,
	output logic     bit_valid,
	output logic     bit_lane0,
	output logic     bit_lane1,
	output logic     bit_last
);

	typedef enum logic {
		IDLE,
		RUN
	} state_t;

	state_t      state_q;
	os_kind_t    kind_q;    // kind of the set in flight
	bit_count_t  pos_q;     // counts down, L-1 is the first bit on the wire
	prbs_t       prbs_q;
	ts4_index_t  ts4_idx_q;
	bit_count_t  start_len_c;
	logic [31:0] ts4_head_c;
	logic [5:0]  gen3_pos;
	logic [4:0]  gen4_pos;
	logic        b0_c;
	logic        b1_c;

	assign gen3_pos = pos_q[5:0];
	assign gen4_pos = pos_q[4:0];

	// 7E0F0 then n, 15-n, 0
	assign ts4_head_c = GEN4_TS4_BASE | {16'h0000, 4'h0, ts4_idx_q, ~ts4_idx_q, 4'h0};

	//////////////////////////////
	// set length per kind
	//////////////////////////////

	always_comb begin
		case (os_kind)
			OS_SLOS1, OS_SLOS2:       start_len_c = LEN_SLOS;
			OS_GEN3_TS1, OS_GEN3_TS2: start_len_c = LEN_GEN3;
			default:                  start_len_c = LEN_GEN4;
		endcase
	end

	//////////////////////////////
	// current bit per lane
	//////////////////////////////

	always_comb begin
		b0_c = 1'b0;
		b1_c = 1'b0;
		case (kind_q)
			OS_SLOS1: begin
				b0_c = prbs_q[0];
				b1_c = prbs_q[0];
			end
			OS_SLOS2: begin
				b0_c = ~prbs_q[0];
				b1_c = ~prbs_q[0];
			end
			OS_GEN3_TS1: begin
				b0_c = GEN3_TS1_LANE0[gen3_pos];
				b1_c = GEN3_TS1_LANE1[gen3_pos];
			end
			OS_GEN3_TS2: begin
				b0_c = GEN3_TS2_LANE0[gen3_pos];
				b1_c = GEN3_TS2_LANE1[gen3_pos];
			end
			OS_GEN4_TS2: begin // gen4 headers are the same on both lanes
				b0_c = GEN4_TS2_HEAD[gen4_pos];
				b1_c = GEN4_TS2_HEAD[gen4_pos];
			end
			OS_GEN4_TS3: begin
				b0_c = GEN4_TS3_HEAD[gen4_pos];
				b1_c = GEN4_TS3_HEAD[gen4_pos];
			end
			OS_GEN4_TS4: begin
				b0_c = ts4_head_c[gen4_pos];
				b1_c = ts4_head_c[gen4_pos];
			end
			default: begin
				b0_c = 1'b0;
				b1_c = 1'b0;
			end
		endcase
	end

	// a restart drops the bit in flight, the gap lets the packer realign
	assign bit_valid = (state_q == RUN) && !os_start;
	assign bit_lane0 = b0_c;
	assign bit_lane1 = b1_c;
	assign bit_last  = bit_valid && (pos_q == '0);

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			state_q   <= IDLE;
			kind_q    <= OS_SLOS1;
			pos_q     <= '0;
			prbs_q    <= PRBS_SEED;
			ts4_idx_q <= TS4_FIRST;
		end else if (abort) begin
			state_q   <= IDLE;
			ts4_idx_q <= TS4_FIRST;
		end else if (os_start) begin
			state_q <= RUN;
			kind_q  <= os_kind;
			pos_q   <= start_len_c - 1'b1;
			prbs_q  <= PRBS_SEED;
			if (os_kind != OS_GEN4_TS4)
				ts4_idx_q <= TS4_FIRST;
		end else if (state_q == RUN) begin
			pos_q  <= pos_q - 1'b1;
			prbs_q <= {prbs_q[9:0], prbs_q[10] ^ prbs_q[8]}; // x^11 + x^9 + 1
			if (pos_q == '0) begin
				state_q <= IDLE;
				if (kind_q == OS_GEN4_TS4) begin
					if (ts4_idx_q == TS4_LAST)
						ts4_idx_q <= TS4_FIRST;
					else
						ts4_idx_q <= ts4_idx_q + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/lane_packer.sv */
// lane packer: per-lane bit to byte shift, lane registers, sent strobe, lanes-on flag
`timescale 1ns/1ps
`default_nettype none

module lane_packer
	import link_pkg::*;
(
	input  logic       fsm_clk,
	input  logic       rst,
	input  logic       bit_valid,
	input  logic       bit_lane0,
	input  logic       bit_lane1,
	input  logic       bit_last,
	input  logic       transport_en,
	input  lane_byte_t transport_byte,
	input  logic       abort,
	output lane_byte_t lane_0_tx,
	output lane_byte_t lane_1_tx,
	output logic       set_done,
	output logic       tx_lanes_on
);

	lane_byte_t            sh0_q; // partial byte, lane 0
	lane_byte_t            sh1_q; // partial byte, lane 1
	lane_byte_t            byte0_c;
	lane_byte_t            byte1_c;
	logic [BYTE_CNT_W-1:0] cnt_q; // bits already in the shift registers
	logic                  byte_end;

	// first bit of a byte ends up in bit 7
	assign byte0_c  = {sh0_q[BYTE_BITS-2:0], bit_lane0};
	assign byte1_c  = {sh1_q[BYTE_BITS-2:0], bit_lane1};
	assign byte_end = bit_valid && (cnt_q == BYTE_CNT_W'(BYTE_BITS - 1));

	//////////////////////////////
	// shift registers
	//////////////////////////////

	always_ff @(posedge fsm_clk) begin
		if (bit_valid) begin
			sh0_q <= byte0_c;
			sh1_q <= byte1_c;
		end
	end

	//////////////////////////////
	// lane registers and status
	//////////////////////////////

	always_ff @(posedge fsm_clk or negedge rst) begin
		if (!rst) begin
			cnt_q       <= '0;
			lane_0_tx   <= '0;
			lane_1_tx   <= '0;
			set_done    <= 1'b0;
			tx_lanes_on <= 1'b0;
		end else begin
			set_done <= 1'b0; // strobe
			if (abort) begin
				cnt_q     <= '0;
				lane_0_tx <= transport_en ? transport_byte : '0; // transport rides lane 0
				lane_1_tx <= '0;
			end else if (!bit_valid) begin
				cnt_q <= '0; // sets always start on a byte boundary
			end else begin
				cnt_q <= cnt_q + 1'b1;
				if (byte_end) begin
					lane_0_tx   <= byte0_c;
					lane_1_tx   <= byte1_c;
					tx_lanes_on <= 1'b1; // sticky until reset
					set_done    <= bit_last;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/data_bus_transmit.sv */
// top level: select decode, bit source and lane packer wired in a chain
`timescale 1ns/1ps
`default_nettype none

module data_bus_transmit
	import link_pkg::*;
(
	input  logic       fsm_clk,
	input  logic       rst,
	input  d_sel_t     d_sel,
	input  lane_byte_t transport_layer_data_in,
	output lane_byte_t lane_0_tx,
	output lane_byte_t lane_1_tx,
	output logic       os_sent,
	output logic       tx_lanes_on
);

	logic       os_start;
	os_kind_t   os_kind;
	logic       transport_en;
	lane_byte_t transport_byte;
	logic       abort;
	logic       bit_valid;
	logic       bit_lane0;
	logic       bit_lane1;
	logic       bit_last;

	// os_sent doubles as set_done back into the decoder
	os_decode u_decode (
		.fsm_clk                 (fsm_clk),
		.rst                     (rst),
		.d_sel                   (d_sel),
		.transport_layer_data_in (transport_layer_data_in),
		.set_done                (os_sent),
		.os_start                (os_start),
		.os_kind                 (os_kind),
		.transport_en            (transport_en),
		.transport_byte          (transport_byte),
		.abort                   (abort)
	);

	os_bit_source u_bit_source (
		.fsm_clk   (fsm_clk),
		.rst       (rst),
		.os_start  (os_start),
		.os_kind   (os_kind),
		.abort     (abort),
		.bit_valid (bit_valid),
		.bit_lane0 (bit_lane0),
		.bit_lane1 (bit_lane1),
		.bit_last  (bit_last)
	);

	lane_packer u_packer (
		.fsm_clk        (fsm_clk),
		.rst            (rst),
		.bit_valid      (bit_valid),
		.bit_lane0      (bit_lane0),
		.bit_lane1      (bit_lane1),
		.bit_last       (bit_last),
		.transport_en   (transport_en),
		.transport_byte (transport_byte),
		.abort          (abort),
		.lane_0_tx      (lane_0_tx),
		.lane_1_tx      (lane_1_tx),
		.set_done       (os_sent),
		.tx_lanes_on    (tx_lanes_on)
	);

endmodule

`default_nettype wire

/* verif/tb_data_bus_transmit.sv */
// testbench: clock, reset, trace reader, prbs11 and ts4 reference model, lane checks
`timescale 1ns/1ps
`default_nettype none

module tb_data_bus_transmit
	import link_pkg::*;
	import ordered_set_pkg::*;
();

	localparam int MAX_RECORDS  = 32;
	localparam int SENT_TIMEOUT = 64; // cycles from the byte before the last one

	logic       fsm_clk;
	logic       rst;
	d_sel_t     d_sel;
	lane_byte_t transport_layer_data_in;
	lane_byte_t lane_0_tx;
	lane_byte_t lane_1_tx;
	logic       os_sent;
	logic       tx_lanes_on;

	logic [63:0] trace_words [0:5*MAX_RECORDS-1]; // five words per record
	lane_byte_t  exp0 [0:255];
	lane_byte_t  exp1 [0:255];
	int          n_bytes;
	ts4_index_t  ts4_n;        // model of the ts4 counter field
	logic [31:0] rng;
	logic        lanes_on_exp;

	data_bus_transmit uut (
		.fsm_clk                 (fsm_clk),
		.rst                     (rst),
		.d_sel                   (d_sel),
		.transport_layer_data_in (transport_layer_data_in),
		.lane_0_tx               (lane_0_tx),
		.lane_1_tx               (lane_1_tx),
		.os_sent                 (os_sent),
		.tx_lanes_on             (tx_lanes_on)
	);

	initial begin
		fsm_clk = 1'b0;
		forever #20 fsm_clk = ~fsm_clk;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic prbs_t prbs_next(input prbs_t s);
		return {s[9:0], s[10] ^ s[8]}; // shift left, feed bit 10 xor bit 8
	endfunction

	function automatic logic [31:0] ts4_header(input ts4_index_t n);
		return {20'h7E0F0, n, 4'd15 - n, 4'h0};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// expected bytes of one set, msb first
	task automatic build_expected(input d_sel_t code, input logic [63:0] pat0,
			input logic [63:0] pat1);
		prbs_t       s;
		logic [31:0] head;
		lane_byte_t  b;
		s    = PRBS_SEED;
		head = ts4_header(ts4_n);
		b    = '0;
		case (code)
			SEL_SLOS1, SEL_SLOS2:       n_bytes = 256;
			SEL_GEN3_TS1, SEL_GEN3_TS2: n_bytes = 8;
			default:                    n_bytes = 4;
		endcase
		for (int k = 0; k < n_bytes; k++) begin
			if (n_bytes == 256) begin
				for (int i = 0; i < 8; i++) begin
					b = {b[6:0], s[0]}; // first bit lands in bit 7
					s = prbs_next(s);
				end
				exp0[k] = (code == SEL_SLOS2) ? ~b : b;
				exp1[k] = exp0[k];
			end else if (code == SEL_GEN4_TS4) begin
				exp0[k] = head[8*(3-k) +: 8];
				exp1[k] = exp0[k];
			end else begin
				exp0[k] = pat0[8*(n_bytes-1-k) +: 8];
				exp1[k] = pat1[8*(n_bytes-1-k) +: 8];
			end
		end
	endtask

	//////////////////////////////
	// checks and timing helpers
	//////////////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected)
			stop_run($sformatf("[FAIL] %s expected %0h actual %0h", name, expected, actual));
	endtask

	task automatic next_cycle();
		@(posedge fsm_clk);
		#2; // drive and sample point
	endtask

	// os_sent low all the way, tx_lanes_on left to the byte point at the end
	task automatic skip_cycles(input int n, input string name);
		for (int i = 0; i < n; i++) begin
			next_cycle();
			check_value($sformatf("%s os_sent", name), 0, os_sent);
			if (i < n - 1)
				check_value($sformatf("%s tx_lanes_on", name), lanes_on_exp, tx_lanes_on);
		end
	endtask

	task automatic wait_sent(input string name, output int waited);
		waited = 0;
		while (os_sent !== 1'b1) begin
			if (waited == SENT_TIMEOUT)
				stop_run($sformatf("timeout, os_sent never rose during %s", name));
			next_cycle();
			waited++;
		end
	endtask

	task automatic check_byte(input string name, input int k);
		lanes_on_exp = 1'b1; // sticky from the first set byte on
		check_value($sformatf("%s tx_lanes_on", name), 1, tx_lanes_on);
		check_value($sformatf("%s lane 0 byte %0d", name, k), exp0[k], lane_0_tx);
		check_value($sformatf("%s lane 1 byte %0d", name, k), exp1[k], lane_1_tx);
	endtask

	//////////////////////////////
	// trace line runners
	//////////////////////////////

	task automatic run_sets(input d_sel_t code, input int count, input logic held,
			input logic [63:0] pat0, input logic [63:0] pat1);
		string name;
		int    waited;
		for (int s = 0; s < count; s++) begin
			name = $sformatf("code %0h set %0d", code, s);
			build_expected(code, pat0, pat1);
			if (s == 0 && !held) begin
				d_sel = code;
				skip_cycles(11, name); // sampled on the next edge, byte 0 ten edges later
			end else begin
				skip_cycles(10, name); // held code, counted from the os_sent edge
			end
			check_byte(name, 0);
			for (int k = 1; k < n_bytes - 1; k++) begin
				skip_cycles(8, name);
				check_byte(name, k);
			end
			wait_sent(name, waited);
			check_value($sformatf("%s os_sent delay", name), 8, waited);
			check_byte(name, n_bytes - 1);
			if (code == SEL_GEN4_TS4)
				ts4_n = (ts4_n == 4'd15) ? 4'd1 : ts4_n + 4'd1;
		end
	endtask

	task automatic run_transport(input lane_byte_t first, input int count);
		lane_byte_t sent [$];
		string      name;
		d_sel = SEL_TRANSPORT;
		for (int j = 0; j < count + 3; j++) begin
			if (j < count) begin
				if (j > 0) begin
					rng = xorshift(rng);
					transport_layer_data_in = rng[7:0];
				end else begin
					transport_layer_data_in = first;
				end
				sent.push_back(transport_layer_data_in);
			end
			if (j >= 3) begin // two edges after the sampling edge
				name = $sformatf("transport byte %0d", j - 3);
				check_value($sformatf("%s lane 0", name), sent[j-3], lane_0_tx);
				check_value($sformatf("%s lane 1", name), 0, lane_1_tx);
			end
			if (j >= 1)
				check_value("transport os_sent", 0, os_sent);
			check_value("transport tx_lanes_on", lanes_on_exp, tx_lanes_on);
			if (j < count + 2)
				next_cycle();
		end
	endtask

	task automatic run_idle(input d_sel_t code, input lane_byte_t first, input int cycles);
		d_sel                   = code;
		transport_layer_data_in = first;
		for (int j = 0; j <= cycles; j++) begin
			if (j > 0) begin // live input data must not leak onto lane 0
				rng = xorshift(rng);
				transport_layer_data_in = rng[7:0];
			end
			if (j >= 3) begin
				check_value($sformatf("idle %0h lane 0", code), 0, lane_0_tx);
				check_value($sformatf("idle %0h lane 1", code), 0, lane_1_tx);
			end
			if (j >= 1)
				check_value($sformatf("idle %0h os_sent", code), 0, os_sent);
			check_value($sformatf("idle %0h tx_lanes_on", code), lanes_on_exp, tx_lanes_on);
			if (j < cycles)
				next_cycle();
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int          rec;
		logic [63:0] code_w;
		logic [63:0] count_w;
		d_sel_t      code;
		d_sel_t      prev_code;
		logic        prev_set;
		rst                     = 1'b0;
		d_sel                   = SEL_IDLE;
		transport_layer_data_in = '0;
		rng                     = 32'ha1ca;
		ts4_n                   = 4'd1;
		lanes_on_exp            = 1'b0;
		prev_code               = SEL_IDLE;
		prev_set                = 1'b0;
		$readmemh("verif/data_bus_transmit_trace.txt", trace_words);
		repeat (3) next_cycle(); // reset held for three edges
		rst = 1'b1;
		check_value("reset lane 0", 0, lane_0_tx);
		check_value("reset lane 1", 0, lane_1_tx);
		check_value("reset os_sent", 0, os_sent);
		check_value("reset tx_lanes_on", 0, tx_lanes_on);
		for (rec = 0; rec < MAX_RECORDS; rec++) begin
			code_w  = trace_words[5*rec];
			count_w = trace_words[5*rec+1];
			if ($isunknown(code_w) || $isunknown(count_w))
				stop_run("trace file is missing or a record is cut short");
			if (count_w == 0)
				break; // end record
			code = code_w[3:0];
			if (code != SEL_GEN4_TS4)
				ts4_n = 4'd1;
			case (code)
				SEL_SLOS1, SEL_SLOS2, SEL_GEN3_TS1, SEL_GEN3_TS2,
				SEL_GEN4_TS2, SEL_GEN4_TS3, SEL_GEN4_TS4: begin
					transport_layer_data_in = trace_words[5*rec+2][7:0]; // ignored by the DUT
					run_sets(code, int'(count_w), prev_set && (prev_code == code),
						trace_words[5*rec+3], trace_words[5*rec+4]);
					prev_set = 1'b1;
				end
				SEL_TRANSPORT: begin
					run_transport(trace_words[5*rec+2][7:0], int'(count_w));
					prev_set = 1'b0;
				end
				default: begin
					run_idle(code, trace_words[5*rec+2][7:0], int'(count_w));
					prev_set = 1'b0;
				end
			endcase
			prev_code = code;
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/data_bus_transmit_trace.txt */
// columns (hex): select code, sets or cycles, transport byte, lane 0 pattern, lane 1 pattern
// patterns are 0 where the bytes are computed or no set goes out; a zero count ends the trace
0 2 00 0 0
1 1 00 0 0
2 2 5a 01000000040098F2 01010000040098F2
3 2 00 01000000040064F2 01010000040064F2
5 2 00 7E04B0F0 7E04B0F0
6 1 c3 7E0690F0 7E0690F0
7 11 00 0 0
f 6 00 0 0
7 2 00 0 0
8 14 3c 0 0
4 5 00 0 0
6 2 00 7E0690F0 7E0690F0
8 6 a5 0 0
9 4 00 0 0
0 0 00 0 0

/* project.f */
verilog/link_pkg.sv
verilog/ordered_set_pkg.sv
verilog/os_decode.sv
verilog/os_bit_source.sv
verilog/lane_packer.sv
verilog/data_bus_transmit.sv
verif/tb_data_bus_transmit.sv

/* Bender.yml */
package:
  name: data_bus_transmit

sources:
  # packages first, then the stages and the top level
  - verilog/link_pkg.sv
  - verilog/ordered_set_pkg.sv
  - verilog/os_decode.sv
  - verilog/os_bit_source.sv
  - verilog/lane_packer.sv
  - verilog/data_bus_transmit.sv
  - target: test
    files:
      - verif/tb_data_bus_transmit.sv
